/* common/obj_dma_pkg.sv */
/* object attribute DMA shared definitions
   widths, fsm states and transfer constants for the sprite attribute copy */

package obj_dma_pkg;

    // running byte count of one transfer
    typedef logic [9:0] dma_count_t;

    // byte address on the main cpu bus, after the board scramble
    typedef logic [9:0] main_addr_t;

    // one byte of attribute data
    typedef logic [7:0] bus_byte_t;

    // object slot inside one attribute bank
    typedef logic [7:0] obj_index_t;

    // which of the four attribute banks
    typedef logic [1:0] bank_sel_t;

    // assembled attribute word
    // bank 3 sits in bits 28:24, then banks 2, 1 and 0 down to bit 0
    typedef logic [28:0] obj_attr_t;

    // dma controller states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        XFER = 2'd1,
        DONE = 2'd2
    } dma_state_t;

    // bytes moved per vblank, 4 banks of 256
    localparam logic [10:0] DMA_LEN = 11'd1024;

    // bank 3 only keeps the low bits of each byte
    localparam logic [2:0] BANK3_W = 3'd5;

endpackage

/* common/obj_wr_if.sv */
/* attribute write path
   one byte write per cycle from the dma fsm into the banked attribute ram */

`timescale 1ns/100ps

interface obj_wr_if;

    // no handshake, the ram takes a write on every cycle we is high
    logic                   we;
    obj_dma_pkg::bank_sel_t bank;
    obj_dma_pkg::obj_index_t index;
    obj_dma_pkg::bus_byte_t  data;

    // dma side
    modport src (
        output we,
        output bank,
        output index,
        output data
    );

    // ram side
    modport dst (
        input  we,
        input  bank,
        input  index,
        input  data
    );

endinterface

/* obj_dma_top.f */
common/obj_dma_pkg.sv
common/obj_wr_if.sv
rtl/obj_dma_counter.sv
rtl/obj_dma_fsm.sv
obj_ram/obj_ram_bank.sv
obj_ram/obj_attr_ram.sv
rtl/obj_dma_top.sv
testbench/obj_dma_tb.sv

/* obj_ram/obj_attr_ram.sv */
/* banked sprite attribute ram
   four banks written one byte at a time, read together as one attribute word */

`timescale 1ns/100ps

module obj_attr_ram #(
    parameter int AW = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    obj_wr_if.dst                   wr,
    input  obj_dma_pkg::obj_index_t obj_addr,
    output obj_dma_pkg::obj_attr_t  obj_data
);

    localparam int B3W = int'(obj_dma_pkg::BANK3_W);

    logic [3:0]     bank_we;
    logic [7:0]     rd_byte [3];
    logic [B3W-1:0] rd_b3;

    // one enable per bank from the write bank number
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            bank_we[b] = wr.we && (wr.bank == obj_dma_pkg::bank_sel_t'(b));
        end
    end

    // full byte banks 0..2
    for (genvar g = 0; g < 3; g++) begin : g_byte_bank
        obj_ram_bank #(
            .DW (8),
            .AW (AW)
        ) obj_ram_bank_i (
            .clk   (clk),
            .we    (bank_we[g]),
            .waddr (wr.index[AW-1:0]),
            .raddr (obj_addr[AW-1:0]),
            .wdata (wr.data),
            .rdata (rd_byte[g])
        );
    end

    // bank 3 drops the upper data bits
    obj_ram_bank #(
        .DW (B3W),
        .AW (AW)
    ) obj_ram_bank3_i (
        .clk   (clk),
        .we    (bank_we[3]),
        .waddr (wr.index[AW-1:0]),
        .raddr (obj_addr[AW-1:0]),
        .wdata (wr.data[B3W-1:0]),
        .rdata (rd_b3)
    );

    // bank 3 on top, bank 0 in the low byte
    assign obj_data = {rd_b3, rd_byte[2], rd_byte[1], rd_byte[0]};

    // a write must carry a known bank, slot and byte
    a_wr_known : assert property (@(posedge clk) disable iff (!rst_n)
        wr.we |-> !$isunknown({wr.bank, wr.index, wr.data}));

endmodule

/* obj_ram/obj_ram_bank.sv */
/* attribute ram bank
   simple dual port memory, synchronous write and registered read */

`timescale 1ns/100ps

module obj_ram_bank #(
    parameter int DW = 8,
    parameter int AW = 8
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  logic [AW-1:0] raddr,
    input  logic [DW-1:0] wdata,
    output logic [DW-1:0] rdata
);

    logic [DW-1:0] mem [2**AW];

    // same address read returns the old word
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

/* rtl/obj_dma_counter.sv */
/* dma transfer counter
   byte count with clear and advance, plus the scrambled main memory address */

`timescale 1ns/100ps

module obj_dma_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  logic                    advance,
    output obj_dma_pkg::dma_count_t count,
    output logic                    last,
    output obj_dma_pkg::main_addr_t wb_adr
);

    obj_dma_pkg::dma_count_t count_q;

    // clear wins over advance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (clear) begin
            count_q <= '0;
        end else if (advance) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign count = count_q;

    // final byte of the block
    assign last = (count_q == obj_dma_pkg::dma_count_t'(obj_dma_pkg::DMA_LEN - 1'b1));

    // the board routes the counter onto the cpu address bus out of order
    always_comb begin
        wb_adr[2] = count_q[0];
        wb_adr[6] = count_q[1];
        wb_adr[3] = count_q[2];
        wb_adr[4] = count_q[3];
        wb_adr[7] = count_q[4];
        wb_adr[8] = count_q[5];
        wb_adr[9] = count_q[6];
        wb_adr[5] = count_q[7];
        wb_adr[0] = count_q[8];
        wb_adr[1] = count_q[9];
    end

    // the controller must stop stepping once the last byte is reached
    a_no_wrap : assert property (@(posedge clk) disable iff (!rst_n)
        !(advance && last && !clear));

endmodule

/* rtl/obj_dma_fsm.sv */
/* object dma controller
   starts on vblank rise, owns the wishbone bus for 1024 reads and
   forwards each acked byte as an attribute ram write */

`timescale 1ns/100ps

module obj_dma_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    vblank,
    input  logic                    wb_ack,
    input  obj_dma_pkg::bus_byte_t  wb_dat_i,
    input  obj_dma_pkg::dma_count_t count,
    input  logic                    last,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic                    cnt_clear,
    output logic                    cnt_advance,
    output logic                    busy,
    obj_wr_if.src                   wr
);

    obj_dma_pkg::dma_state_t state;
    obj_dma_pkg::dma_state_t state_nxt;
    logic                    vblank_q;
    logic                    vb_rise;
    logic                    in_xfer;
    logic                    byte_done;

    // previous vblank level for edge detect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank_q <= 1'b0;
        end else begin
            vblank_q <= vblank;
        end
    end

    assign vb_rise   = vblank & ~vblank_q;
    assign in_xfer   = (state == obj_dma_pkg::XFER);
    // a byte moves when the slave acks our strobe
    assign byte_done = in_xfer & wb_ack;

    always_comb begin
        state_nxt = state;
        case (state)
            obj_dma_pkg::IDLE: begin
                // edges seen in XFER or DONE are simply dropped
                if (vb_rise) begin
                    state_nxt = obj_dma_pkg::XFER;
                end
            end
            obj_dma_pkg::XFER: begin
                if (byte_done && last) begin
                    state_nxt = obj_dma_pkg::DONE;
                end
            end
            obj_dma_pkg::DONE: begin
                // one idle cycle with the bus released
                state_nxt = obj_dma_pkg::IDLE;
            end
            default: begin
                state_nxt = obj_dma_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= obj_dma_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // holding cyc is bus ownership, stb stays up for back to back reads
    assign wb_cyc = in_xfer;
    assign wb_stb = in_xfer;
    // read only master
    assign wb_we  = 1'b0;
    assign busy   = in_xfer;

    // restart the count as the transfer begins
    assign cnt_clear   = (state == obj_dma_pkg::IDLE) & vb_rise;
    // the count parks at 1023 after the final byte
    assign cnt_advance = byte_done & ~last;

    // bank from top count bits, slot from the low byte
    assign wr.we    = byte_done;
    assign wr.bank  = count[9:8];
    assign wr.index = count[7:0];
    assign wr.data  = wb_dat_i;

    // strobe and address hold until the slave acks
    a_adr_hold : assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(count));

    // every block starts from the first byte
    a_start_at_zero : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_cyc) |-> count == '0);

endmodule

/* rtl/obj_dma_top.sv */
/* object attribute dma top level
   wishbone read master copying sprite attributes into the banked ram */

`timescale 1ns/100ps

module obj_dma_top #(
    parameter int OBJ_AW = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    vblank,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output obj_dma_pkg::main_addr_t wb_adr,
    input  obj_dma_pkg::bus_byte_t  wb_dat_i,
    input  logic                    wb_ack,
    input  obj_dma_pkg::obj_index_t obj_addr,
    output obj_dma_pkg::obj_attr_t  obj_data,
    output logic                    dma_busy
);

    obj_dma_pkg::dma_count_t count;
    logic                    last;
    logic                    cnt_clear;
    logic                    cnt_advance;

    // fsm to ram byte writes
    obj_wr_if wr_if ();

    obj_dma_fsm obj_dma_fsm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .vblank      (vblank),
        .wb_ack      (wb_ack),
        .wb_dat_i    (wb_dat_i),
        .count       (count),
        .last        (last),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .cnt_clear   (cnt_clear),
        .cnt_advance (cnt_advance),
        .busy        (dma_busy),
        .wr          (wr_if.src)
    );

    obj_dma_counter obj_dma_counter_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (cnt_clear),
        .advance (cnt_advance),
        .count   (count),
        .last    (last),
        .wb_adr  (wb_adr)
    );

    obj_attr_ram #(
        .AW (OBJ_AW)
    ) obj_attr_ram_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr_if.dst),
        .obj_addr (obj_addr),
        .obj_data (obj_data)
    );

endmodule

/* testbench/obj_dma_tb.sv */
/* object attribute dma testbench
   wishbone memory model with random ack delay, checks bus order and ram contents */

`timescale 1ns/100ps

module obj_dma_tb;

    localparam int N_CHK = 10;

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic                           vblank;
    logic                           wb_cyc;
    logic                           wb_stb;
    logic                           wb_we;
    obj_dma_pkg::main_addr_t        wb_adr;
    obj_dma_pkg::bus_byte_t         wb_dat_i;
    logic                           wb_ack;
    obj_dma_pkg::obj_index_t        obj_addr;
    obj_dma_pkg::obj_attr_t         obj_data;
    logic                           dma_busy;

    // main memory model and bus log
    logic [7:0]                     mem [1024];
    logic [9:0]                     addr_log [$];
    int                             wait_left = 0;
    int                             seed = 32'h10a2c061;

    // check table, object index and whether a new dma runs first
    obj_dma_pkg::obj_index_t        chk_idx [N_CHK] = '{8'd0, 8'd1, 8'd255, 8'd128, 8'd7,
                                                        8'd64, 8'd200, 8'd31, 8'd170, 8'd85};
    bit                             chk_dma [N_CHK] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
                                                        1'b1, 1'b0, 1'b0, 1'b0, 1'b0};

    obj_dma_top obj_dma_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .vblank   (vblank),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .obj_addr (obj_addr),
        .obj_data (obj_data),
        .dma_busy (dma_busy)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("ERR t=%0t %s: got %h expected %h", $time, msg, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out waiting for %s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped on timeout");
    endtask

    // inputs change and outputs are sampled 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // board wiring, count bit i lands on address bit dst[i]
    function automatic logic [9:0] scramble(input logic [9:0] cnt);
        int         dst [10] = '{2, 6, 3, 4, 7, 8, 9, 5, 0, 1};
        logic [9:0] a;
        a = '0;
        for (int i = 0; i < 10; i++) begin
            a[dst[i]] = cnt[i];
        end
        return a;
    endfunction

    // bank b slot k holds the byte fetched at count b*256+k
    function automatic logic [28:0] expected_attr(input logic [7:0] k);
        logic [7:0] b [4];
        for (int bank = 0; bank < 4; bank++) begin
            b[bank] = mem[scramble(10'(bank * 256 + k))];
        end
        return {b[3][4:0], b[2], b[1], b[0]};
    endfunction

    task automatic fill_memory();
        for (int a = 0; a < 1024; a++) begin
            mem[a] = 8'($random(seed));
        end
    endtask

    // wishbone slave, ack after 0..3 wait cycles, logs every acked address
    always @(posedge clk) begin
        #2;
        if (wb_cyc) begin
            check(wb_we, 1'b0, "wb_we high during dma");
        end
        if (wb_cyc && wb_stb && wait_left == 0) begin
            wb_ack   = 1'b1;
            wb_dat_i = mem[wb_adr];
            addr_log.push_back(wb_adr);
            wait_left = $random(seed) & 3;
        end else begin
            wb_ack = 1'b0;
            if (wb_cyc && wb_stb) begin
                wait_left--;
            end
        end
    end

    // one full transfer with a second vblank rise in the middle of it
    task automatic run_dma();
        int n;
        int seen [1024];
        addr_log.delete();
        vblank = 1'b1;
        for (n = 0; n < 10 && !dma_busy; n++) begin
            step();
        end
        if (!dma_busy) begin
            timeout_fail("dma_busy to rise");
        end
        check(wb_cyc, 1'b1, "wb_cyc low while busy");
        vblank = 1'b0;
        for (n = 0; n < 6000 && dma_busy; n++) begin
            step();
            // retrigger while busy, must be ignored
            if (n == 40) begin
                vblank = 1'b1;
            end else if (n == 45) begin
                vblank = 1'b0;
            end
        end
        if (dma_busy) begin
            timeout_fail("dma_busy to fall");
        end
        check(wb_cyc, 1'b0, "wb_cyc after release");
        check(wb_stb, 1'b0, "wb_stb after release");
        // a dropped retrigger leaves the bus free after the block
        for (n = 0; n < 8; n++) begin
            step();
            check({wb_cyc, dma_busy}, 2'b00, "bus taken again after release");
        end
        check(addr_log.size(), 1024, "acked transfer count");
        foreach (seen[a]) begin
            seen[a] = 0;
        end
        for (int i = 0; i < 1024; i++) begin
            check(addr_log[i], scramble(10'(i)), "bus address order");
            seen[addr_log[i]]++;
        end
        for (int a = 0; a < 1024; a++) begin
            check(seen[a], 1, "address hit count");
        end
    endtask

    // walk the table, reading one attribute per entry
    task automatic check_table();
        for (int i = 0; i < N_CHK; i++) begin
            if (chk_dma[i]) begin
                run_dma();
            end
            obj_addr = chk_idx[i];
            step();
            check(obj_data, expected_attr(chk_idx[i]), "attribute word");
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        vblank   = 1'b0;
        wb_ack   = 1'b0;
        wb_dat_i = '0;
        obj_addr = '0;
        fill_memory();
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // idle bus until vblank
        for (int n = 0; n < 20; n++) begin
            step();
            check({wb_cyc, wb_stb, wb_we, dma_busy}, 4'b0000, "idle outputs after reset");
        end

        run_dma();
        check_table();

        // new memory image, every bank must be rewritten
        fill_memory();
        check_table();

        $display("RESULT: PASS");
        $finish;
    end

endmodule
